//--- Bender.yml
package:
  name: prefetch_front_end

sources:
  # design, package first
  - src/prefetch_pkg.sv
  - src/prefetch.sv
  - src/fetch_engine.sv
  - src/prefetch_fifo.sv
  - src/prefetch_top.sv

  # simulation only
  - target: test
    files:
      - bench/code_mem_model.sv
      - bench/tb_prefetch_top.sv

//--- bench/code_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module code_mem_model (
    input  logic        clk,
    input  logic        mem_req,
    input  logic [31:0] mem_addr,
    input  logic        mem_su,
    output logic        mem_rvalid,
    output logic [31:0] mem_rdata
);

    // 64k of code, linear addresses wrap on bits 15:0
    logic [7:0]  code [65536];

    // every issued read, oldest first
    logic [31:0] addr_log [$];
    logic        su_log [$];

    integer      seed = 32'ha2c73bad;
    logic [31:0] rd_addr;
    int          delay;

    // each byte is the xor of the two bytes of its address
    initial begin
        for (int i = 0; i < 65536; i++) begin
            code[i] = 8'(i) ^ 8'(i >> 8);
        end
    end

    initial begin
        mem_rvalid = 1'b0;
        mem_rdata  = 32'd0;
        forever begin
            @(posedge clk);
            if (mem_req === 1'b1) begin
                rd_addr = mem_addr;
                addr_log.push_back(rd_addr);
                su_log.push_back(mem_su);
                // answer after 1 to 4 cycles
                delay = 1 + ($unsigned($random(seed)) % 4);
                repeat (delay - 1) @(posedge clk);
                #10;
                mem_rvalid = 1'b1;
                for (int i = 0; i < 4; i++) begin
                    mem_rdata[8*i +: 8] = code[16'(rd_addr + 32'(i))];
                end
                @(posedge clk);
                #10;
                mem_rvalid = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- bench/tb_prefetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_prefetch_top import prefetch_pkg::*; ();

    logic        clk;
    logic        pr_reset;
    logic        jump_do;
    logic [31:0] jump_eip;
    seg_desc_t   jump_cs;
    logic [1:0]  cpl;
    logic        reset_prefetch;
    dec_window_t window;
    logic        accept_do;
    logic [2:0]  accept_length;
    logic        mem_req;
    logic [31:0] mem_addr;
    logic        mem_su;
    logic        mem_rvalid;
    logic [31:0] mem_rdata;
    logic [31:0] delivered_eip;

    integer      seed = 32'ha2c73bad;
    // log position at the last jump
    int          mark = 0;

    prefetch_top uut (.*);

    code_mem_model code_mem (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // 2000 cycles for each of the six tests
    initial begin
        repeat (6 * 2000) @(posedge clk);
        $display("timeout: tests still running after %0d cycles", 6 * 2000);
        fail_run();
    end

    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    task automatic fail_run();
        $display("*** FAILED ***");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_window(input dec_window_t got, input dec_window_t exp,
                                input string what);
        if (got !== exp) begin
            $display("** Error at %0t: %s: bytes %h count %0d fault %0b, expected %h %0d %0b",
                     $time, what, got.bytes, got.count, got.fault,
                     exp.bytes, exp.count, exp.fault);
            fail_run();
        end
    endtask

    task automatic check_eip(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
        if (got !== exp) begin
            $display("** Error at %0t: %s: got %h, expected %h", $time, what, got, exp);
            fail_run();
        end
    endtask

    task automatic check_addr(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
        if (got !== exp) begin
            $display("** Error at %0t: %s: got %h, expected %h", $time, what, got, exp);
            fail_run();
        end
    endtask

    function automatic logic [7:0] pattern_byte(input logic [31:0] a);
        return a[7:0] ^ a[15:8];
    endfunction

    function automatic seg_desc_t make_desc(input logic [31:0] base, input logic [19:0] lim,
                                            input logic g);
        seg_desc_t d;
        d          = '0;
        d.base_hi  = base[31:24];
        d.base_mid = base[23:16];
        d.base_lo  = base[15:0];
        d.limit_hi = lim[19:16];
        d.limit_lo = lim[15:0];
        d.g        = g;
        // present, dpl 0, execute/read code
        d.access   = 8'h9A;
        return d;
    endfunction

    task automatic do_jump(input logic [31:0] base, input logic [31:0] eip,
                           input logic [19:0] lim, input logic g, input logic [1:0] pl);
        jump_cs  = make_desc(base, lim, g);
        jump_eip = eip;
        cpl      = pl;
        jump_do  = 1'b1;
        next_cycle();
        jump_do  = 1'b0;
        mark     = code_mem.addr_log.size();
        check_eip(delivered_eip, base + eip, "delivered_eip after jump");
    endtask

    // word reads since the last jump must run from first to last
    task automatic check_reads(input logic [31:0] first, input logic [31:0] last);
        int n;
        n = int'((last - first) >> 2) + 1;
        if (code_mem.addr_log.size() - mark != n) begin
            $display("%0d code reads seen, expected %0d", code_mem.addr_log.size() - mark, n);
            fail_run();
        end
        for (int i = 0; i < n; i++) begin
            check_addr(code_mem.addr_log[mark + i], first + 32'(4 * i), "code read address");
        end
    endtask

    task automatic check_su(input logic exp);
        for (int i = mark; i < code_mem.su_log.size(); i++) begin
            if (code_mem.su_log[i] !== exp) begin
                $display("** Error at %0t: mem_su was %0b on read %0d, expected %0b",
                         $time, code_mem.su_log[i], i, exp);
                fail_run();
            end
        end
    endtask

    // take n bytes from start with random accepts, eip lags accepts by two cycles
    task automatic stream_bytes(input logic [31:0] start, input int n, input bit at_limit);
        dec_window_t exp;
        int total;
        int lag;
        int left;
        int cap;
        int len;
        total = 0;
        lag   = 0;
        while (total < n) begin
            check_eip(delivered_eip, start + 32'(lag), "delivered_eip while streaming");
            lag  = total;
            left = n - total;
            // at most four bytes, and none past the segment limit
            cap  = (at_limit && left < 4) ? left : 4;
            exp.count = (int'(window.count) > cap) ? 3'(cap) : window.count;
            exp.bytes = 32'd0;
            for (int i = 0; i < int'(exp.count); i++) begin
                exp.bytes[8*i +: 8] = pattern_byte(start + 32'(total + i));
            end
            // marker may already trail the last legal byte
            exp.fault = (at_limit && int'(window.count) == left) ? window.fault : 1'b0;
            check_window(window, exp, "decoder window");
            len = 0;
            if (exp.count != 0 && ($random(seed) & 1) == 1) begin
                len = 1 + int'($unsigned($random(seed)) % exp.count);
                if (len > left) begin
                    len = left;
                end
            end
            accept_do     = len != 0;
            accept_length = 3'(len);
            total        += len;
            next_cycle();
        end
        accept_do = 1'b0;
        next_cycle();
        check_eip(delivered_eip, start + 32'(n), "delivered_eip after stream");
    endtask

    task automatic expect_fault();
        dec_window_t exp;
        for (int i = 0; i < 8 && !window.fault; i++) begin
            next_cycle();
        end
        exp.bytes = 32'd0;
        exp.count = 3'd0;
        exp.fault = 1'b1;
        check_window(window, exp, "limit fault after last byte");
    endtask

    task automatic test_startup();
        dec_window_t exp;
        exp = '0;
        check_window(window, exp, "window after reset");
        stream_bytes(startup_linear, 16, 1'b1);
        expect_fault();
        check_reads(startup_linear, startup_linear + 32'd12);
    endtask

    task automatic test_jump();
        do_jump(32'h0001_2000, 32'h34, 20'hFFFFF, 1'b0, 2'd0);
        stream_bytes(32'h0001_2034, 40, 1'b0);
        check_su(1'b0);
    endtask

    // limit is the last legal offset, so 9 bytes from eip 0x102
    task automatic test_limit();
        do_jump(32'h0000_2000, 32'h102, 20'h0010A, 1'b0, 2'd0);
        stream_bytes(32'h0000_2102, 9, 1'b1);
        expect_fault();
        check_reads(32'h0000_2100, 32'h0000_2108);
    endtask

    // one 4k page, user level
    task automatic test_user_page();
        do_jump(32'h0000_4000, 32'h0, 20'h00000, 1'b1, 2'd3);
        stream_bytes(32'h0000_4000, 64, 1'b0);
        check_su(1'b1);
    endtask

    task automatic test_refetch();
        stream_bytes(32'h0000_4040, 13, 1'b0);
        while (window.count == 0) begin
            next_cycle();
        end
        // one byte still in the accept delay register when the refetch hits
        accept_do     = 1'b1;
        accept_length = 3'd1;
        next_cycle();
        accept_do      = 1'b0;
        reset_prefetch = 1'b1;
        next_cycle();
        reset_prefetch = 1'b0;
        stream_bytes(32'h0000_404E, 40, 1'b0);
    endtask

    task automatic test_backpressure();
        dec_window_t exp;
        int n1;
        do_jump(32'h0000_8000, 32'h40, 20'hFFFFF, 1'b0, 2'd0);
        repeat (60) next_cycle();
        n1 = code_mem.addr_log.size() - mark;
        repeat (30) next_cycle();
        if (n1 != fifo_depth / 4 || code_mem.addr_log.size() - mark != n1) begin
            $display("reads did not stop on a full queue, %0d then %0d reads",
                     n1, code_mem.addr_log.size() - mark);
            fail_run();
        end
        exp.count = 3'd4;
        exp.fault = 1'b0;
        for (int i = 0; i < 4; i++) begin
            exp.bytes[8*i +: 8] = pattern_byte(32'h0000_8040 + 32'(i));
        end
        check_window(window, exp, "window of a full queue");
        stream_bytes(32'h0000_8040, 64, 1'b0);
    endtask

    initial begin
        pr_reset       = 1'b1;
        jump_do        = 1'b0;
        jump_eip       = 32'd0;
        jump_cs        = '0;
        cpl            = 2'd0;
        reset_prefetch = 1'b0;
        accept_do      = 1'b0;
        accept_length  = 3'd0;
        repeat (10) @(posedge clk);
        #10;
        pr_reset = 1'b0;
        test_startup();
        test_jump();
        test_limit();
        test_user_page();
        test_refetch();
        test_backpressure();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
src/prefetch_pkg.sv
src/prefetch.sv
src/fetch_engine.sv
src/prefetch_fifo.sv
src/prefetch_top.sv
bench/code_mem_model.sv
bench/tb_prefetch_top.sv

//--- src/fetch_engine.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_engine import prefetch_pkg::*; (
    input  logic        clk,
    input  logic        pr_reset,
    input  logic        flush,

    // window from prefetch controller
    input  fetch_req_t  fetch_req,
    // free bytes in the queue
    input  logic [4:0]  fifo_free,

    // code memory port, one read outstanding at most
    output logic        mem_req,
    output logic [31:0] mem_addr,
    output logic        mem_su,
    input  logic        mem_rvalid,
    input  logic [31:0] mem_rdata,

    output fetch_rsp_t  fetch_rsp
);

    // read in flight, and whether a flush has orphaned it
    logic        pending;
    logic        stale;

    // captured at issue, used when the word comes back
    logic [1:0]  cap_off;
    logic [2:0]  cap_len;

    // registered response
    logic        rsp_valid;
    logic [2:0]  rsp_len;
    logic [31:0] rsp_data;

    logic [2:0]  word_len;
    logic [2:0]  req_len;
    logic        issue;
    logic [31:0] shifted;
    logic [31:0] trimmed;

    // bytes from the offset to the end of the aligned word
    assign word_len = 3'd4 - {1'b0, fetch_req.address[1:0]};
    assign req_len  = (fetch_req.length < {2'b00, word_len}) ? fetch_req.length[2:0]
                                                             : word_len;

    // rsp_valid also blocks, prefetch moves linear only the cycle after it
    assign issue = fetch_req.length != 5'd0 && fifo_free >= 5'd4 &&
                   !pending && !rsp_valid && !flush;

    // first wanted byte down to bits 7:0
    assign shifted = mem_rdata >> {cap_off, 3'b000};

    // bytes past the captured length read as zero
    always_comb begin
        trimmed = shifted;
        for (int i = 0; i < 4; i++) begin
            if (i >= int'(cap_len)) begin
                trimmed[8*i +: 8] = 8'h00;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pr_reset) begin
            mem_req   <= 1'b0;
            pending   <= 1'b0;
            stale     <= 1'b0;
            rsp_valid <= 1'b0;
        end else begin
            mem_req   <= issue;
            // a stale word, or one landing on a flush, is thrown away
            rsp_valid <= mem_rvalid && pending && !stale && !flush;
            if (issue) begin
                pending <= 1'b1;
            end else if (mem_rvalid) begin
                pending <= 1'b0;
            end
            if (mem_rvalid) begin
                stale <= 1'b0;
            end else if (flush && pending) begin
                stale <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            mem_addr <= {fetch_req.address[31:2], 2'b00};
            mem_su   <= fetch_req.su;
            cap_off  <= fetch_req.address[1:0];
            cap_len  <= req_len;
        end
        if (mem_rvalid) begin
            rsp_len  <= cap_len;
            rsp_data <= trimmed;
        end
    end

    assign fetch_rsp.valid  = rsp_valid;
    assign fetch_rsp.length = rsp_len;
    assign fetch_rsp.data   = rsp_data;

    // memory answers only what was asked
    assert property (@(posedge clk) disable iff (pr_reset) mem_rvalid |-> pending);

endmodule

`default_nettype wire

//--- src/prefetch.sv
`timescale 1ns/1ps
`default_nettype none

module prefetch import prefetch_pkg::*; (
    input  logic        clk,
    input  logic        pr_reset,

    // jump, loads eip and cs descriptor
    input  logic        jump_do,
    input  logic [31:0] jump_eip,
    input  seg_desc_t   jump_cs,
    input  logic [1:0]  cpl,

    // refetch from delivered eip
    input  logic        reset_prefetch,

    // response from fetch engine
    input  fetch_rsp_t  fetch_rsp,

    // decoder consumption
    input  logic        accept_do,
    input  logic [2:0]  accept_length,

    output fetch_req_t  fetch_req,
    output logic        limit_do,
    output logic [31:0] delivered_eip
);

    // fetch point state
    logic [31:0] linear;
    logic [31:0] limit;
    logic        limit_signaled;

    // accept delayed by one cycle before it reaches delivered_eip
    logic        accept_do_1;
    logic [2:0]  accept_length_1;

    // descriptor decode
    logic [31:0] cs_base;
    logic [31:0] cs_limit;
    logic [32:0] jump_span;
    logic [31:0] jump_limit;

    // refetch point, includes an accept still in the delay register
    logic [31:0] restart_linear;
    logic [31:0] rsp_len;

    assign cs_base  = {jump_cs.base_hi, jump_cs.base_mid, jump_cs.base_lo};
    assign cs_limit = jump_cs.g ? {jump_cs.limit_hi, jump_cs.limit_lo, 12'hFFF}
                                : {12'd0, jump_cs.limit_hi, jump_cs.limit_lo};

    // bytes from eip up to and including the limit byte
    // 33 bits so that a full 4G segment does not wrap to zero
    assign jump_span  = {1'b0, cs_limit} - {1'b0, jump_eip} + 33'd1;
    assign jump_limit = (cs_limit < jump_eip) ? 32'd0
                      : (jump_span[32] ? 32'hFFFF_FFFF : jump_span[31:0]);

    assign restart_linear = accept_do_1 ? delivered_eip + 32'(accept_length_1)
                                        : delivered_eip;

    assign rsp_len = 32'(fetch_rsp.length);

    // window toward the fetch engine
    assign fetch_req.address = linear;
    assign fetch_req.length  = (limit > 32'(fetch_max)) ? 5'(fetch_max) : limit[4:0];
    // 0 = supervisor, 1 = user
    assign fetch_req.su      = cpl == 2'd3;

    // one marker per fetch point, raised once the limit is used up
    assign limit_do = limit == 32'd0 && !limit_signaled;

    always_ff @(posedge clk) begin
        if (pr_reset) begin
            accept_do_1 <= 1'b0;
        end else begin
            accept_do_1 <= accept_do;
        end
        accept_length_1 <= accept_length;
    end

    always_ff @(posedge clk) begin
        if (pr_reset) begin
            linear        <= startup_linear;
            limit         <= startup_limit;
            delivered_eip <= startup_linear;
        end else if (jump_do) begin
            // pending accept is dropped, the jump target wins
            linear        <= cs_base + jump_eip;
            limit         <= jump_limit;
            delivered_eip <= cs_base + jump_eip;
        end else begin
            if (reset_prefetch) begin
                // step back from linear, limit grows by the same amount
                linear <= restart_linear;
                limit  <= limit + (linear - restart_linear);
            end else if (fetch_rsp.valid) begin
                linear <= linear + rsp_len;
                limit  <= limit - rsp_len;
            end
            if (accept_do_1) begin
                delivered_eip <= delivered_eip + 32'(accept_length_1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pr_reset || jump_do || reset_prefetch) begin
            limit_signaled <= 1'b0;
        end else if (limit_do) begin
            limit_signaled <= 1'b1;
        end
    end

    // fetch engine must never hand back more than the window allowed
    assert property (@(posedge clk) disable iff (pr_reset)
        fetch_rsp.valid && !jump_do && !reset_prefetch |-> rsp_len <= limit);

    // a second marker needs a new fetch point first
    assert property (@(posedge clk) disable iff (pr_reset)
        limit_do && !jump_do && !reset_prefetch
        |=> (!limit_do until (jump_do || reset_prefetch)));

endmodule

`default_nettype wire

//--- src/prefetch_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module prefetch_fifo import prefetch_pkg::*; (
    input  logic        clk,
    input  logic        pr_reset,
    input  logic        flush,

    // bytes from fetch engine
    input  fetch_rsp_t  fetch_rsp,
    // segment limit reached, queue a fault marker behind the tail
    input  logic        limit_do,

    // decoder side
    input  logic        accept_do,
    input  logic [2:0]  accept_length,
    output dec_window_t window,

    // free bytes, holds off new reads
    output logic [4:0]  fifo_free
);

    // circular byte store
    logic [7:0] mem [fifo_depth];

    logic [$clog2(fifo_depth)-1:0] rd_ptr;
    logic [$clog2(fifo_depth)-1:0] wr_ptr;
    // 0..fifo_depth
    logic [4:0] used;
    // fault marker sits right after the last queued byte
    logic       fault_q;

    logic       push;
    logic       pop;
    logic [2:0] push_len;
    logic [2:0] pop_len;

    // a flush wins over anything arriving in the same cycle
    assign push     = fetch_rsp.valid && !flush;
    assign pop      = accept_do && !flush;
    assign push_len = push ? fetch_rsp.length : 3'd0;
    assign pop_len  = pop ? accept_length : 3'd0;

    always_ff @(posedge clk) begin
        if (pr_reset || flush) begin
            rd_ptr  <= '0;
            wr_ptr  <= '0;
            used    <= 5'd0;
            fault_q <= 1'b0;
        end else begin
            wr_ptr <= wr_ptr + ($clog2(fifo_depth))'(push_len);
            rd_ptr <= rd_ptr + ($clog2(fifo_depth))'(pop_len);
            used   <= used + 5'(push_len) - 5'(pop_len);
            if (limit_do) begin
                fault_q <= 1'b1;
            end
        end
    end

    // byte lanes land at consecutive slots, wrapping at the end
    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (i < int'(push_len)) begin
                mem[wr_ptr + ($clog2(fifo_depth))'(i)] <= fetch_rsp.data[8*i +: 8];
            end
        end
    end

    // up to four bytes from the head
    always_comb begin
        window.count = (used > 5'd4) ? 3'd4 : used[2:0];
        window.bytes = 32'd0;
        for (int i = 0; i < 4; i++) begin
            if (i < int'(window.count)) begin
                window.bytes[8*i +: 8] = mem[rd_ptr + ($clog2(fifo_depth))'(i)];
            end
        end
        // marker visible only once the tail is inside the window
        window.fault = fault_q && used <= 5'd4;
    end

    assign fifo_free = 5'(fifo_depth) - used;

    // engine checks free space at issue, nothing may arrive beyond it
    assert property (@(posedge clk) disable iff (pr_reset)
        push |-> 5'(fetch_rsp.length) <= fifo_free);

    // decoder takes only bytes it was shown
    assert property (@(posedge clk) disable iff (pr_reset)
        accept_do |-> accept_length != 3'd0 && accept_length <= window.count);

endmodule

`default_nettype wire

//--- src/prefetch_pkg.sv
`default_nettype none

package prefetch_pkg;

    // cached code-segment descriptor, laid out like the 64-bit gdt entry
    // base  = base_hi : base_mid : base_lo
    // limit = limit_hi : limit_lo, scaled by 4k when g is set
    typedef struct packed {
        logic [7:0]  base_hi;
        // granularity, 1 = limit counts 4k pages
        logic        g;
        // default operand size
        logic        d;
        // long mode code, not used by the fetch path
        logic        l;
        logic        avl;
        logic [3:0]  limit_hi;
        // type, dpl, present
        logic [7:0]  access;
        logic [7:0]  base_mid;
        logic [15:0] base_lo;
        logic [15:0] limit_lo;
    } seg_desc_t;

    // fetch window from the prefetch controller to the fetch engine
    typedef struct packed {
        // linear address of the first byte wanted
        logic [31:0] address;
        // bytes allowed before the segment limit, capped at fetch_max
        logic [4:0]  length;
        // user access, cpl 3
        logic        su;
    } fetch_req_t;

    // bytes returned by one code-memory read, already shifted and trimmed
    typedef struct packed {
        logic        valid;
        // 1..4 bytes
        logic [2:0]  length;
        // lowest address sits in bits 7:0
        logic [31:0] data;
    } fetch_rsp_t;

    // what the decoder sees at the head of the byte queue
    typedef struct packed {
        // byte 0 of the window in bits 7:0, uncounted bytes read as zero
        logic [31:0] bytes;
        // 0..4 valid bytes
        logic [2:0]  count;
        // the byte right after the counted ones is a limit fault
        logic        fault;
    } dec_window_t;

    // fetch point after system reset, just below the 1M boundary
    localparam logic [31:0] startup_linear = 32'h000F_FFF0;
    localparam logic [31:0] startup_limit  = 32'd16;

    // byte queue size
    localparam int fifo_depth = 16;

    // largest fetch window handed to the fetch engine
    localparam int fetch_max = 16;

endpackage

`default_nettype wire

//--- src/prefetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module prefetch_top import prefetch_pkg::*; (
    input  logic        clk,
    input  logic        pr_reset,

    // control
    input  logic        jump_do,
    input  logic [31:0] jump_eip,
    input  seg_desc_t   jump_cs,
    input  logic [1:0]  cpl,
    input  logic        reset_prefetch,

    // decoder
    output dec_window_t window,
    input  logic        accept_do,
    input  logic [2:0]  accept_length,

    // code memory
    output logic        mem_req,
    output logic [31:0] mem_addr,
    output logic        mem_su,
    input  logic        mem_rvalid,
    input  logic [31:0] mem_rdata,

    output logic [31:0] delivered_eip
);

    logic       flush;
    fetch_req_t fetch_req;
    fetch_rsp_t fetch_rsp;
    logic       limit_do;
    logic [4:0] fifo_free;

    // both events drop queued bytes and any read in flight
    assign flush = jump_do || reset_prefetch;

    prefetch u_prefetch (
        .clk            (clk),
        .pr_reset       (pr_reset),
        .jump_do        (jump_do),
        .jump_eip       (jump_eip),
        .jump_cs        (jump_cs),
        .cpl            (cpl),
        .reset_prefetch (reset_prefetch),
        .fetch_rsp      (fetch_rsp),
        .accept_do      (accept_do),
        .accept_length  (accept_length),
        .fetch_req      (fetch_req),
        .limit_do       (limit_do),
        .delivered_eip  (delivered_eip)
    );

    fetch_engine u_fetch_engine (
        .clk        (clk),
        .pr_reset   (pr_reset),
        .flush      (flush),
        .fetch_req  (fetch_req),
        .fifo_free  (fifo_free),
        .mem_req    (mem_req),
        .mem_addr   (mem_addr),
        .mem_su     (mem_su),
        .mem_rvalid (mem_rvalid),
        .mem_rdata  (mem_rdata),
        .fetch_rsp  (fetch_rsp)
    );

    prefetch_fifo u_prefetch_fifo (
        .clk           (clk),
        .pr_reset      (pr_reset),
        .flush         (flush),
        .fetch_rsp     (fetch_rsp),
        .limit_do      (limit_do),
        .accept_do     (accept_do),
        .accept_length (accept_length),
        .window        (window),
        .fifo_free     (fifo_free)
    );

endmodule

`default_nettype wire
